//--- design/qspi_mem_ctrl.sv
`timescale 1ns/100ps

module qspi_mem_ctrl #(
    parameter qspi_mem_pkg::bus_addr_t BASE_ADDR      = 32'h1000_0000,
    parameter int unsigned             MEM_SIZE       = 4096,
    parameter int unsigned             LATENCY_CYCLES = 3
) (
    input  logic                     clk_i,
    input  logic                     nrst_i,

    input  logic                     req_i,
    input  logic                     we_i,
    input  qspi_mem_pkg::xfer_size_e size_i,
    input  qspi_mem_pkg::bus_addr_t  addr_i,
    input  qspi_mem_pkg::data_t      wdata_i,
    output logic                     ack_o,
    output qspi_mem_pkg::data_t      rdata_o,

    output logic                     spi_clk_o,
    output logic                     spi_cs_o,      // active low
    output qspi_mem_pkg::nibble_t    spi_sio_o,
    input  qspi_mem_pkg::nibble_t    spi_sio_i,
    output logic                     spi_sio_oe_o,
    input  logic                     spi_dqs_i
);

    qspi_txn_if txn ();
    qspi_phy_if phy ();

    qspi_req_decode #(
        .BASE_ADDR (BASE_ADDR),
        .MEM_SIZE  (MEM_SIZE)
    ) u_decode (
        .clk_i   (clk_i),
        .nrst_i  (nrst_i),
        .req_i   (req_i),
        .we_i    (we_i),
        .size_i  (size_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .txn     (txn.dec)
    );

    qspi_sequencer #(
        .LATENCY_CYCLES (LATENCY_CYCLES)
    ) u_sequencer (
        .clk_i     (clk_i),
        .nrst_i    (nrst_i),
        .req_i     (req_i),
        .txn       (txn.seq),
        .phy       (phy.seq),
        .spi_dqs_i (spi_dqs_i),
        .ack_o     (ack_o),
        .spi_cs_o  (spi_cs_o)
    );

    qspi_phy u_phy (
        .clk_i        (clk_i),
        .nrst_i       (nrst_i),
        .phy          (phy.phy),
        .spi_sio_i    (spi_sio_i),
        .spi_clk_o    (spi_clk_o),
        .spi_sio_o    (spi_sio_o),
        .spi_sio_oe_o (spi_sio_oe_o),
        .rdata_o      (rdata_o)
    );

endmodule

//--- design/qspi_mem_pkg.sv
package qspi_mem_pkg;

    // system bus byte address
    typedef logic [31:0] bus_addr_t;

    // address relative to the start of the memory window
    typedef logic [25:0] mem_addr_t;

    typedef logic [31:0] data_t;
    typedef logic [3:0]  nibble_t;   // one slice of the four data lines
    typedef logic [7:0]  cmd_t;

    typedef enum logic {
        SIZE_BYTE,
        SIZE_WORD
    } xfer_size_e;

    localparam cmd_t CMD_READ  = 8'h0A;
    localparam cmd_t CMD_WRITE = 8'h02;

    // the 32-bit command address goes out as eight nibbles
    localparam int CMD_ADDR_NIBBLES = 8;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_CMD,
        ST_ADDR,
        ST_LATENCY,
        ST_DQS_WAIT,     // read only, memory has not raised its strobe yet
        ST_WRITE,
        ST_READ,
        ST_TAIL,         // lets the last write nibble reach the pins
        ST_DONE
    } seq_state_e;

endpackage

//--- design/qspi_phy.sv
`timescale 1ns/100ps

module qspi_phy (
    input  logic                   clk_i,
    input  logic                   nrst_i,
    qspi_phy_if.phy                phy,
    input  qspi_mem_pkg::nibble_t  spi_sio_i,
    output logic                   spi_clk_o,
    output qspi_mem_pkg::nibble_t  spi_sio_o,
    output logic                   spi_sio_oe_o,
    output qspi_mem_pkg::data_t    rdata_o
);

    logic [2:0] rx_idx;     // nibbles taken so far in this read
    logic [2:0] rx_sel;

    // the first nibble of a byte is its high half
    assign rx_sel = {rx_idx[2:1], ~rx_idx[0]};

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            spi_clk_o    <= 1'b0;
            spi_sio_oe_o <= 1'b0;
        end else begin
            spi_clk_o    <= phy.sck_en ? !spi_clk_o : 1'b0;   // idles low
            spi_sio_oe_o <= phy.tx_oe;
        end
    end

    always_ff @(posedge clk_i) begin
        spi_sio_o <= phy.tx_nibble;
    end

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            rx_idx      <= '0;
            phy.rx_word <= '0;
        end else if (phy.rx_clear) begin
            // upper bytes stay zero on a byte read
            rx_idx      <= '0;
            phy.rx_word <= '0;
        end else if (phy.rx_en) begin
            phy.rx_word[rx_sel * 4 +: 4] <= spi_sio_i;
            rx_idx                       <= rx_idx + 3'd1;
        end
    end

    assign rdata_o = phy.rx_word;

    // the bus must be released by the time read data is sampled
    a_no_drive_on_read: assert property (
        @(posedge clk_i) disable iff (!nrst_i)
        phy.rx_en |-> !phy.tx_oe && !spi_sio_oe_o
    );

endmodule

//--- design/qspi_phy_if.sv
`timescale 1ns/100ps

interface qspi_phy_if;
    import qspi_mem_pkg::*;

    logic    sck_en;
    nibble_t tx_nibble;
    logic    tx_oe;      // all four data lines switch together
    logic    rx_en;      // take one nibble this cycle
    logic    rx_clear;
    data_t   rx_word;

    modport seq (
        output sck_en, tx_nibble, tx_oe, rx_en, rx_clear
    );

    // rx_word is written by the pin-level logic only
    modport phy (
        input  sck_en, tx_nibble, tx_oe, rx_en, rx_clear,
        output rx_word
    );

endinterface

//--- design/qspi_req_decode.sv
`timescale 1ns/100ps

module qspi_req_decode #(
    parameter qspi_mem_pkg::bus_addr_t BASE_ADDR = 32'h1000_0000,
    parameter int unsigned             MEM_SIZE  = 4096
) (
    input  logic                     clk_i,
    input  logic                     nrst_i,
    input  logic                     req_i,
    input  logic                     we_i,
    input  qspi_mem_pkg::xfer_size_e size_i,
    input  qspi_mem_pkg::bus_addr_t  addr_i,
    input  qspi_mem_pkg::data_t      wdata_i,
    qspi_txn_if.dec                  txn
);
    import qspi_mem_pkg::*;

    bus_addr_t   rel_addr;
    mem_addr_t   mem_addr;
    logic [34:0] row_col;
    logic        in_window;
    logic        in_flight;   // covers the start cycle before busy rises
    logic        accept;

    assign rel_addr  = addr_i - BASE_ADDR;
    assign in_window = rel_addr < MEM_SIZE;   // addresses below the base wrap to large values
    assign mem_addr  = rel_addr[25:0];
    assign accept    = req_i && in_window && !txn.busy && !in_flight;

    // the three leading zeros fall off the top of the 32-bit command address
    assign row_col = {3'b000, mem_addr[25:10], 1'b0, mem_addr[9:0], 5'b00000};

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            txn.start <= 1'b0;
            in_flight <= 1'b0;
        end else begin
            txn.start <= accept;
            if (accept) begin
                in_flight <= 1'b1;
            end else if (txn.done) begin
                in_flight <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            txn.we       <= we_i;
            txn.size     <= size_i;
            txn.wdata    <= wdata_i;
            txn.cmd_addr <= row_col[31:0];
        end
    end

    // the sequencer must be back in idle whenever a new transfer starts
    a_start_not_busy: assert property (
        @(posedge clk_i) disable iff (!nrst_i)
        txn.start |-> !txn.busy
    );

endmodule

//--- design/qspi_sequencer.sv
`timescale 1ns/100ps

module qspi_sequencer #(
    parameter int unsigned LATENCY_CYCLES = 3
) (
    input  logic     clk_i,
    input  logic     nrst_i,
    input  logic     req_i,
    qspi_txn_if.seq  txn,
    qspi_phy_if.seq  phy,
    input  logic     spi_dqs_i,
    output logic     ack_o,
    output logic     spi_cs_o
);
    import qspi_mem_pkg::*;

    // every clk_i cycle is one memory clock edge, so two per latency period
    localparam int             LAT_W     = $clog2(2 * LATENCY_CYCLES);
    localparam logic [LAT_W-1:0] LAT_LAST = LAT_W'(2 * LATENCY_CYCLES - 1);
    localparam logic [2:0]     ADDR_LAST = 3'(CMD_ADDR_NIBBLES - 1);

    seq_state_e       state;
    logic [2:0]       nib_cnt;
    logic [LAT_W-1:0] lat_cnt;
    logic [2:0]       data_last;
    logic [2:0]       addr_sel;
    logic [2:0]       data_sel;
    cmd_t             cmd;

    assign data_last = (txn.size == SIZE_WORD) ? 3'd7 : 3'd1;
    assign cmd       = txn.we ? CMD_WRITE : CMD_READ;
    assign addr_sel  = ADDR_LAST - nib_cnt;              // address goes out msb first
    assign data_sel  = {nib_cnt[2:1], ~nib_cnt[0]};      // byte 0 first, high nibble first

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            state   <= ST_IDLE;
            nib_cnt <= '0;
            lat_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    nib_cnt <= '0;
                    if (txn.start) begin
                        state <= ST_CMD;
                    end
                end

                ST_CMD: begin
                    if (nib_cnt[0]) begin
                        state   <= ST_ADDR;
                        nib_cnt <= '0;
                    end else begin
                        nib_cnt <= nib_cnt + 3'd1;
                    end
                end

                ST_ADDR: begin
                    if (nib_cnt == ADDR_LAST) begin
                        state   <= ST_LATENCY;
                        nib_cnt <= '0;
                        lat_cnt <= LAT_LAST;
                    end else begin
                        nib_cnt <= nib_cnt + 3'd1;
                    end
                end

                ST_LATENCY: begin
                    if (lat_cnt == '0) begin
                        state <= txn.we ? ST_WRITE : ST_DQS_WAIT;
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end

                ST_DQS_WAIT: begin
                    if (spi_dqs_i) begin   // memory signals that read data follows
                        state <= ST_READ;
                    end
                end

                ST_WRITE: begin
                    if (nib_cnt == data_last) begin
                        state <= ST_TAIL;
                    end else begin
                        nib_cnt <= nib_cnt + 3'd1;
                    end
                end

                ST_READ: begin
                    if (nib_cnt == data_last) begin
                        state <= ST_DONE;
                    end else begin
                        nib_cnt <= nib_cnt + 3'd1;
                    end
                end

                ST_TAIL: begin
                    state <= ST_DONE;
                end

                ST_DONE: begin
                    if (!req_i) begin   // requester has seen ack fall
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        case (state)
            ST_CMD:   phy.tx_nibble = nib_cnt[0] ? cmd[3:0] : cmd[7:4];
            ST_ADDR:  phy.tx_nibble = txn.cmd_addr[addr_sel * 4 +: 4];
            ST_WRITE: phy.tx_nibble = txn.wdata[data_sel * 4 +: 4];
            default:  phy.tx_nibble = '0;
        endcase
    end

    assign phy.sck_en   = state inside {ST_CMD, ST_ADDR, ST_LATENCY, ST_DQS_WAIT,
                                        ST_WRITE, ST_READ};
    assign phy.tx_oe    = state inside {ST_CMD, ST_ADDR, ST_WRITE};
    assign phy.rx_en    = state == ST_READ;
    assign phy.rx_clear = state == ST_DQS_WAIT;

    assign txn.busy = state != ST_IDLE;
    assign txn.done = (state == ST_TAIL) || (state == ST_READ && nib_cnt == data_last);

    assign spi_cs_o = (state == ST_IDLE) || (state == ST_DONE);
    assign ack_o    = !spi_cs_o;

    // the request fields come from the decoder and must hold for the whole transfer
    a_fields_stable: assert property (
        @(posedge clk_i) disable iff (!nrst_i)
        txn.busy && $past(txn.busy) |-> $stable(txn.we) && $stable(txn.size)
            && $stable(txn.cmd_addr) && $stable(txn.wdata)
    );

endmodule

//--- design/qspi_txn_if.sv
`timescale 1ns/100ps

interface qspi_txn_if;
    import qspi_mem_pkg::*;

    logic       start;      // one cycle, request accepted
    logic       we;
    xfer_size_e size;
    bus_addr_t  cmd_addr;   // already in row/column form
    data_t      wdata;
    logic       done;       // one cycle, memory side finished
    logic       busy;

    // the decoder only takes a new request while busy is low
    modport dec (
        output start, we, size, cmd_addr, wdata,
        input  done, busy
    );

    modport seq (
        input  start, we, size, cmd_addr, wdata,
        output done, busy
    );

endinterface

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_qspi_mem -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit $status
fi

./obj_dir/Vtb_qspi_mem
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0

//--- tests/psram_model.sv
`timescale 1ns/100ps

module psram_model #(
    parameter int LATENCY_CYCLES = 3
) (
    input  logic        clk_i,
    input  logic        spi_cs_i,       // active low
    input  logic [3:0]  spi_sio_i,
    input  logic        spi_sio_oe_i,
    output logic [3:0]  spi_sio_o,
    output logic        spi_dqs_o,
    output logic [7:0]  last_cmd_o,
    output logic [31:0] last_addr_o
);
    import qspi_mem_pkg::*;

    logic [7:0]  mem [0:4095];
    logic [31:0] rng_state = 32'hc3de_ee73;
    logic [3:0]  sio_r     = 4'h0;
    logic        dqs_r     = 1'b0;
    logic [7:0]  cmd_r     = 8'h00;
    logic [31:0] addr_r    = 32'h0;
    logic        active    = 1'b0;
    logic [7:0]  cmd;
    logic [31:0] addr;
    logic [11:0] base;
    logic [3:0]  wr_hi;
    logic [7:0]  rd_byte;
    int          cyc;
    int          nib_cnt;
    int          dqs_cyc;
    int          rd_nib;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[12'(i)] = 8'(i) ^ 8'(i >> 4) ^ 8'h5a;   // every address bit shows up in the fill
        end
    end

    // samples and drives on the falling edge, half a cycle away from the controller
    always @(negedge clk_i) begin
        if (spi_cs_i) begin
            active = 1'b0;
            dqs_r  = 1'b0;
            sio_r  = 4'h0;
        end else begin
            if (!active) begin
                active  = 1'b1;
                cyc     = 0;
                nib_cnt = 0;
                dqs_cyc = -1;
                rd_nib  = -1;
            end else begin
                cyc++;
            end

            if (spi_sio_oe_i) begin
                if (nib_cnt < 2) begin
                    cmd = {cmd[3:0], spi_sio_i};
                end else if (nib_cnt < 10) begin
                    addr = {addr[27:0], spi_sio_i};
                end else if (nib_cnt % 2 == 0) begin
                    wr_hi = spi_sio_i;   // high nibble of a write byte
                end else begin
                    mem[base + 12'((nib_cnt - 10) / 2)] = {wr_hi, spi_sio_i};
                end
                nib_cnt++;
                if (nib_cnt == 10) begin
                    cmd_r  = cmd;
                    addr_r = addr;
                    // column starts above five zero bits, row above one more zero
                    base   = {addr[17:16], addr[14:5]};
                    if (cmd == CMD_READ) begin
                        rng_state = xorshift32(rng_state);
                        dqs_cyc   = cyc + 2 * LATENCY_CYCLES + int'(rng_state % 6);
                    end
                end
            end

            if (dqs_cyc >= 0 && cyc == dqs_cyc) begin
                dqs_r  = 1'b1;
                rd_nib = 0;
            end else if (rd_nib >= 0) begin
                rd_byte = mem[base + 12'(rd_nib / 2)];
                sio_r   = (rd_nib % 2 == 0) ? rd_byte[7:4] : rd_byte[3:0];
                rd_nib++;
            end
        end
    end

    assign spi_sio_o   = sio_r;
    assign spi_dqs_o   = dqs_r;
    assign last_cmd_o  = cmd_r;
    assign last_addr_o = addr_r;

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic nrst_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;   // 20 ns period
    end

    // reset is released on a falling edge, away from the flops' sampling edge
    initial begin
        nrst_o = 1'b0;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        nrst_o = 1'b1;
    end

endmodule

//--- tests/tb_qspi_mem.sv
`timescale 1ns/100ps

module tb_qspi_mem;
    import qspi_mem_pkg::*;

    localparam bus_addr_t   BASE_ADDR      = 32'h1000_0000;
    localparam int unsigned MEM_SIZE       = 4096;
    localparam int unsigned LATENCY_CYCLES = 3;
    localparam int          TIMEOUT        = 200;

    logic       clk_i;
    logic       nrst_i;
    logic       req_i;
    logic       we_i;
    xfer_size_e size_i;
    bus_addr_t  addr_i;
    data_t      wdata_i;
    logic       ack_o;
    data_t      rdata_o;
    logic       spi_clk_o;
    logic       spi_cs_o;
    nibble_t    spi_sio_o;
    nibble_t    spi_sio_i;
    logic       spi_sio_oe_o;
    logic       spi_dqs_i;
    cmd_t       model_cmd;
    bus_addr_t  model_addr;

    // stimulus table, one entry per transfer
    string      name_q[$];
    logic       we_q[$];
    xfer_size_e size_q[$];
    bus_addr_t  addr_q[$];
    data_t      wdata_q[$];
    data_t      exp_q[$];
    logic       valid_q[$];   // low for a request outside the window

    tb_clk_gen clk_gen (
        .clk_o  (clk_i),
        .nrst_o (nrst_i)
    );

    qspi_mem_ctrl #(
        .BASE_ADDR      (BASE_ADDR),
        .MEM_SIZE       (MEM_SIZE),
        .LATENCY_CYCLES (LATENCY_CYCLES)
    ) dut_i (
        .clk_i        (clk_i),
        .nrst_i       (nrst_i),
        .req_i        (req_i),
        .we_i         (we_i),
        .size_i       (size_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .ack_o        (ack_o),
        .rdata_o      (rdata_o),
        .spi_clk_o    (spi_clk_o),
        .spi_cs_o     (spi_cs_o),
        .spi_sio_o    (spi_sio_o),
        .spi_sio_i    (spi_sio_i),
        .spi_sio_oe_o (spi_sio_oe_o),
        .spi_dqs_i    (spi_dqs_i)
    );

    psram_model #(
        .LATENCY_CYCLES (LATENCY_CYCLES)
    ) psram (
        .clk_i        (clk_i),
        .spi_cs_i     (spi_cs_o),
        .spi_sio_i    (spi_sio_o),
        .spi_sio_oe_i (spi_sio_oe_o),
        .spi_sio_o    (spi_sio_i),
        .spi_dqs_o    (spi_dqs_i),
        .last_cmd_o   (model_cmd),
        .last_addr_o  (model_addr)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            stop_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // row bits 25..10 land at 31..16, column bits 9..0 at 14..5
    function automatic bus_addr_t expected_cmd_addr(input bus_addr_t addr);
        bus_addr_t rel;
        rel = addr - BASE_ADDR;
        return (32'(rel[25:10]) << 16) | (32'(rel[9:0]) << 5);
    endfunction

    task automatic add_step(input string name, input logic we, input xfer_size_e size,
                            input bus_addr_t addr, input data_t wdata, input data_t exp,
                            input logic valid);
        name_q.push_back(name);
        we_q.push_back(we);
        size_q.push_back(size);
        addr_q.push_back(addr);
        wdata_q.push_back(wdata);
        exp_q.push_back(exp);
        valid_q.push_back(valid);
    endtask

    task automatic build_table();
        add_step("word_write_a",      1'b1, SIZE_WORD, 32'h1000_0010, 32'hdead_beef, 32'h0, 1'b1);
        add_step("word_read_a",       1'b0, SIZE_WORD, 32'h1000_0010, 32'h0, 32'hdead_beef, 1'b1);
        add_step("word_write_b",      1'b1, SIZE_WORD, 32'h1000_0404, 32'h1234_5678, 32'h0, 1'b1);
        add_step("byte_write_b2",     1'b1, SIZE_BYTE, 32'h1000_0406, 32'h0000_00a5, 32'h0, 1'b1);
        add_step("byte_read_b2",      1'b0, SIZE_BYTE, 32'h1000_0406, 32'h0, 32'h0000_00a5, 1'b1);
        add_step("word_read_b",       1'b0, SIZE_WORD, 32'h1000_0404, 32'h0, 32'h12a5_5678, 1'b1);
        add_step("outside_window",    1'b0, SIZE_WORD, BASE_ADDR + MEM_SIZE, 32'h0, 32'h0, 1'b0);
        add_step("read_after_reject", 1'b0, SIZE_WORD, 32'h1000_0010, 32'h0, 32'hdead_beef, 1'b1);
        add_step("word_write_c",      1'b1, SIZE_WORD, 32'h1000_0ffc, 32'hcafe_f00d, 32'h0, 1'b1);
        add_step("word_read_c",       1'b0, SIZE_WORD, 32'h1000_0ffc, 32'h0, 32'hcafe_f00d, 1'b1);
        add_step("byte_write_d",      1'b1, SIZE_BYTE, 32'h1000_0801, 32'h0000_003c, 32'h0, 1'b1);
        add_step("byte_read_d",       1'b0, SIZE_BYTE, 32'h1000_0801, 32'h0, 32'h0000_003c, 1'b1);
        add_step("word_read_b_again", 1'b0, SIZE_WORD, 32'h1000_0404, 32'h0, 32'h12a5_5678, 1'b1);
        add_step("word_read_c_again", 1'b0, SIZE_WORD, 32'h1000_0ffc, 32'h0, 32'hcafe_f00d, 1'b1);
    endtask

    // called on a falling edge, returns on a falling edge with req_i low
    task automatic run_step(input int i);
        int   wait_cnt;
        int   ack_cnt;
        int   nbytes;
        int   exp_ack;
        int   exp_edges;
        int   edges;
        logic prev_clk;
        req_i   = 1'b1;
        we_i    = we_q[i];
        size_i  = size_q[i];
        addr_i  = addr_q[i];
        wdata_i = wdata_q[i];
        wait_cnt = 0;
        while (!ack_o) begin
            @(negedge clk_i);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
                stop_run($sformatf("%s: ack_o never went high", name_q[i]));
            end
        end
        check_value({name_q[i], " ack delay"}, 32'd2, wait_cnt);
        ack_cnt  = 0;
        edges    = 0;
        prev_clk = spi_clk_o;
        while (ack_o) begin
            ack_cnt++;
            @(negedge clk_i);
            if (spi_clk_o !== prev_clk) begin
                edges++;
            end
            prev_clk = spi_clk_o;
            if (ack_cnt > TIMEOUT) begin
                stop_run($sformatf("%s: ack_o never went low", name_q[i]));
            end
        end
        if (we_q[i]) begin
            nbytes    = (size_q[i] == SIZE_WORD) ? 4 : 1;
            // one memory clock edge per command, address, latency and data cycle
            exp_edges = 2 + CMD_ADDR_NIBBLES + 2 * LATENCY_CYCLES + 2 * nbytes;
            exp_ack   = exp_edges + 1;   // the tail cycle has no clock edge
            check_value({name_q[i], " ack cycles"}, exp_ack, ack_cnt);
            check_value({name_q[i], " clock edges"}, exp_edges, edges);
            check_value({name_q[i], " command"}, 32'(CMD_WRITE), 32'(model_cmd));
        end else begin
            check_value({name_q[i], " rdata"}, exp_q[i], rdata_o);
            check_value({name_q[i], " command"}, 32'(CMD_READ), 32'(model_cmd));
        end
        check_value({name_q[i], " address"}, expected_cmd_addr(addr_q[i]), model_addr);
        req_i = 1'b0;
        @(negedge clk_i);
    endtask

    task automatic check_no_response(input int i);
        req_i   = 1'b1;
        we_i    = we_q[i];
        size_i  = size_q[i];
        addr_i  = addr_q[i];
        wdata_i = wdata_q[i];
        repeat (40) begin
            @(negedge clk_i);
            check_value({name_q[i], " ack_o"}, 32'd0, 32'(ack_o));
            check_value({name_q[i], " spi_cs_o"}, 32'd1, 32'(spi_cs_o));
        end
        req_i = 1'b0;
        @(negedge clk_i);
    endtask

    initial begin
        int wait_cnt;
        req_i   = 1'b0;
        we_i    = 1'b0;
        size_i  = SIZE_WORD;
        addr_i  = '0;
        wdata_i = '0;
        build_table();
        wait_cnt = 0;
        while (nrst_i !== 1'b1) begin
            @(negedge clk_i);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
                stop_run("reset was never released");
            end
        end
        @(negedge clk_i);
        check_value("reset ack_o", 32'd0, 32'(ack_o));
        check_value("reset spi_cs_o", 32'd1, 32'(spi_cs_o));
        check_value("reset spi_clk_o", 32'd0, 32'(spi_clk_o));
        check_value("reset spi_sio_oe_o", 32'd0, 32'(spi_sio_oe_o));
        for (int i = 0; i < name_q.size(); i++) begin
            if (valid_q[i]) begin
                run_step(i);
            end else begin
                check_no_response(i);
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- vlog.f
design/qspi_mem_pkg.sv
design/qspi_txn_if.sv
design/qspi_phy_if.sv
design/qspi_req_decode.sv
design/qspi_sequencer.sv
design/qspi_phy.sv
design/qspi_mem_ctrl.sv
tests/tb_clk_gen.sv
tests/psram_model.sv
tests/tb_qspi_mem.sv
